// File: design/csr_decode.sv
// decodes SYSTEM instructions only; anything else, including funct3 4, is passed on as illegal
module csr_decode (
  input logic clk,
  input logic reset_x,
  input logic in_valid,
  input logic [rv_isa_pkg::xlen-1:0] in_instr,
  input logic [rv_isa_pkg::xlen-1:0] in_pc,
  input logic [rv_isa_pkg::xlen-1:0] in_rs1_data,
  csr_op_if.stage_out op
);

  logic [rv_isa_pkg::opcode_w-1:0] opcode;
  logic [rv_isa_pkg::funct3_w-1:0] funct3;
  logic [rv_isa_pkg::reg_idx_w-1:0] rd_idx;
  logic [rv_isa_pkg::reg_idx_w-1:0] rs1_idx;
  logic [rv_isa_pkg::imm_w-1:0] imm12;

  rv_isa_pkg::sys_kind_t kind_d;
  logic write_en_d;
  logic use_uimm;
  logic [rv_isa_pkg::xlen-1:0] operand_d;

  // field extraction
  assign opcode = in_instr[rv_isa_pkg::opcode_lsb +: rv_isa_pkg::opcode_w];
  assign rd_idx = in_instr[rv_isa_pkg::rd_lsb +: rv_isa_pkg::reg_idx_w];
  assign funct3 = in_instr[rv_isa_pkg::funct3_lsb +: rv_isa_pkg::funct3_w];
  assign rs1_idx = in_instr[rv_isa_pkg::rs1_lsb +: rv_isa_pkg::reg_idx_w];
  assign imm12 = in_instr[rv_isa_pkg::imm_lsb +: rv_isa_pkg::imm_w];

  always_comb begin
    kind_d = rv_isa_pkg::kind_illegal;
    write_en_d = 1'b0;
    use_uimm = 1'b0;
    if (opcode == rv_isa_pkg::opcode_system) begin
      case (funct3)
        rv_isa_pkg::funct3_priv: begin
          if (imm12 == rv_isa_pkg::imm_ecall) begin
            kind_d = rv_isa_pkg::kind_ecall;
          end else if (imm12 == rv_isa_pkg::imm_mret) begin
            kind_d = rv_isa_pkg::kind_mret;
          end
        end
        rv_isa_pkg::funct3_csrrw: begin
          kind_d = rv_isa_pkg::kind_csrw;
          write_en_d = 1'b1;
        end
        rv_isa_pkg::funct3_csrrwi: begin
          kind_d = rv_isa_pkg::kind_csrw;
          write_en_d = 1'b1;
          use_uimm = 1'b1;
        end
        // set and clear with x0 or uimm 0 only read
        rv_isa_pkg::funct3_csrrs: begin
          kind_d = rv_isa_pkg::kind_csrs;
          write_en_d = (rs1_idx != '0);
        end
        rv_isa_pkg::funct3_csrrsi: begin
          kind_d = rv_isa_pkg::kind_csrs;
          write_en_d = (rs1_idx != '0);
          use_uimm = 1'b1;
        end
        rv_isa_pkg::funct3_csrrc: begin
          kind_d = rv_isa_pkg::kind_csrc;
          write_en_d = (rs1_idx != '0);
        end
        rv_isa_pkg::funct3_csrrci: begin
          kind_d = rv_isa_pkg::kind_csrc;
          write_en_d = (rs1_idx != '0);
          use_uimm = 1'b1;
        end
        default: begin
          kind_d = rv_isa_pkg::kind_illegal;
        end
      endcase
    end
  end

  // uimm sits in the rs1 field, zero-extended
  assign operand_d = use_uimm ?
      {{(rv_isa_pkg::xlen - rv_isa_pkg::reg_idx_w){1'b0}}, rs1_idx} : in_rs1_data;

  always_ff @(posedge clk) begin
    if (!reset_x) begin
      op.valid <= 1'b0;
    end else begin
      op.valid <= in_valid;
    end
  end

  // payload only loads on a new instruction
  always_ff @(posedge clk) begin
    if (!reset_x) begin
      op.kind <= rv_isa_pkg::kind_illegal;
      op.addr <= '0;
      op.rd <= '0;
      op.operand <= '0;
      op.write_en <= 1'b0;
      op.pc <= '0;
      op.instr <= '0;
    end else if (in_valid) begin
      op.kind <= kind_d;
      op.addr <= imm12;
      op.rd <= rd_idx;
      op.operand <= operand_d;
      op.write_en <= write_en_d;
      op.pc <= in_pc;
      op.instr <= in_instr;
    end
  end

  // no operation escapes to the CSR file while reset is held
  a_valid_low_in_reset : assert property (@(posedge clk) !reset_x |=> !op.valid);

endmodule

// File: design/csr_file.sv
// direct mode mtvec only; mie and mip are plain storage, no interrupts are taken
module csr_file (
  input logic clk,
  input logic reset_x,
  csr_op_if.stage_in op,
  output logic wb_valid,
  output logic [rv_isa_pkg::reg_idx_w-1:0] wb_rd,
  output logic [rv_isa_pkg::xlen-1:0] wb_data,
  output logic redirect_valid,
  output logic [rv_isa_pkg::xlen-1:0] redirect_pc,
  output logic [csr_pkg::priv_w-1:0] priv_mode
);

  // machine CSRs
  csr_pkg::mstatus_t mstatus_q;
  logic [rv_isa_pkg::xlen-1:0] mie_q;
  logic [rv_isa_pkg::xlen-1:0] mtvec_q;
  logic [rv_isa_pkg::xlen-1:0] mscratch_q;
  logic [rv_isa_pkg::xlen-1:0] mepc_q;
  logic [rv_isa_pkg::xlen-1:0] mcause_q;
  logic [rv_isa_pkg::xlen-1:0] mtval_q;
  logic [rv_isa_pkg::xlen-1:0] mip_q;
  logic [csr_pkg::priv_w-1:0] priv_q;

  logic [rv_isa_pkg::xlen-1:0] csr_old;
  logic [rv_isa_pkg::xlen-1:0] csr_new;
  logic addr_hit;
  logic is_csr;
  logic in_m;
  logic do_csr;
  logic do_mret;
  logic do_trap;
  logic [csr_pkg::cause_w-1:0] cause;

  // read mux
  always_comb begin
    addr_hit = 1'b1;
    case (op.addr)
      csr_pkg::addr_mstatus: csr_old = mstatus_q.raw;
      csr_pkg::addr_mie: csr_old = mie_q;
      csr_pkg::addr_mtvec: csr_old = mtvec_q;
      csr_pkg::addr_mscratch: csr_old = mscratch_q;
      csr_pkg::addr_mepc: csr_old = mepc_q;
      csr_pkg::addr_mcause: csr_old = mcause_q;
      csr_pkg::addr_mtval: csr_old = mtval_q;
      csr_pkg::addr_mip: csr_old = mip_q;
      default: begin
        csr_old = '0;
        addr_hit = 1'b0;
      end
    endcase
  end

  always_comb begin
    case (op.kind)
      rv_isa_pkg::kind_csrs: csr_new = csr_old | op.operand;
      rv_isa_pkg::kind_csrc: csr_new = csr_old & ~op.operand;
      default: csr_new = op.operand;
    endcase
  end

  assign is_csr = (op.kind == rv_isa_pkg::kind_csrw) ||
                  (op.kind == rv_isa_pkg::kind_csrs) ||
                  (op.kind == rv_isa_pkg::kind_csrc);
  assign in_m = (priv_q == csr_pkg::priv_m);

  // every implemented CSR is machine level, so U mode may touch none of them
  assign do_csr = op.valid && is_csr && addr_hit && in_m;
  assign do_mret = op.valid && (op.kind == rv_isa_pkg::kind_mret) && in_m;
  // whatever neither commits as a CSR access nor returns takes a trap
  assign do_trap = op.valid && !do_csr && !do_mret;

  always_comb begin
    if (op.kind == rv_isa_pkg::kind_ecall) begin
      cause = in_m ? csr_pkg::cause_ecall_m : csr_pkg::cause_ecall_u;
    end else begin
      cause = csr_pkg::cause_illegal;
    end
  end

  // CSR state and privilege mode
  always_ff @(posedge clk) begin
    if (!reset_x) begin
      mstatus_q.raw <= csr_pkg::mstatus_reset;
      mie_q <= '0;
      mtvec_q <= '0;
      mscratch_q <= csr_pkg::mscratch_reset;
      mepc_q <= '0;
      mcause_q <= '0;
      mtval_q <= '0;
      mip_q <= '0;
      priv_q <= csr_pkg::priv_m;
    end else if (do_trap) begin
      mepc_q <= op.pc;
      mcause_q <= {{(rv_isa_pkg::xlen - csr_pkg::cause_w){1'b0}}, cause};
      mstatus_q.fields.mpie <= mstatus_q.fields.mie;
      mstatus_q.fields.mie <= 1'b0;
      mstatus_q.fields.mpp <= priv_q;
      priv_q <= csr_pkg::priv_m;
      // faulting instruction word goes to mtval
      if (cause == csr_pkg::cause_illegal) begin
        mtval_q <= op.instr;
      end
    end else if (do_mret) begin
      mstatus_q.fields.mie <= mstatus_q.fields.mpie;
      mstatus_q.fields.mpie <= 1'b1;
      mstatus_q.fields.mpp <= csr_pkg::priv_u;
      // mpp encodings other than M fall back to U
      if (mstatus_q.fields.mpp == csr_pkg::priv_m) begin
        priv_q <= csr_pkg::priv_m;
      end else begin
        priv_q <= csr_pkg::priv_u;
      end
    end else if (do_csr && op.write_en) begin
      case (op.addr)
        csr_pkg::addr_mstatus: mstatus_q.raw <= csr_new;
        csr_pkg::addr_mie: mie_q <= csr_new;
        csr_pkg::addr_mtvec: mtvec_q <= csr_new;
        csr_pkg::addr_mscratch: mscratch_q <= csr_new;
        csr_pkg::addr_mepc: mepc_q <= csr_new;
        csr_pkg::addr_mcause: mcause_q <= csr_new;
        csr_pkg::addr_mtval: mtval_q <= csr_new;
        csr_pkg::addr_mip: mip_q <= csr_new;
        default: begin
        end
      endcase
    end
  end

  // output strobes, one cycle per committed operation
  always_ff @(posedge clk) begin
    if (!reset_x) begin
      wb_valid <= 1'b0;
      redirect_valid <= 1'b0;
    end else begin
      wb_valid <= do_csr && (op.rd != '0);
      redirect_valid <= do_trap || do_mret;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_x) begin
      wb_rd <= '0;
      wb_data <= '0;
      redirect_pc <= '0;
    end else if (op.valid) begin
      wb_rd <= op.rd;
      wb_data <= csr_old;
      // trap target is mtvec base, mret target is mepc
      if (do_mret) begin
        redirect_pc <= mepc_q;
      end else begin
        redirect_pc <= {mtvec_q[rv_isa_pkg::xlen-1:2], 2'b00};
      end
    end
  end

  assign priv_mode = priv_q;

  a_one_output : assert property (@(posedge clk) disable iff (!reset_x)
    !(wb_valid && redirect_valid));

  a_legal_priv : assert property (@(posedge clk) disable iff (!reset_x)
    (priv_mode == csr_pkg::priv_u) || (priv_mode == csr_pkg::priv_m));

endmodule

// File: design/csr_op_if.sv
// one decoded SYSTEM operation per valid strobe; no ready, the consumer must accept every cycle
interface csr_op_if;

  logic valid;
  rv_isa_pkg::sys_kind_t kind;
  logic [csr_pkg::csr_addr_w-1:0] addr;
  logic [rv_isa_pkg::reg_idx_w-1:0] rd;
  logic [rv_isa_pkg::xlen-1:0] operand;
  logic write_en;
  logic [rv_isa_pkg::xlen-1:0] pc;
  logic [rv_isa_pkg::xlen-1:0] instr;

  modport stage_out (
    output valid, kind, addr, rd, operand, write_en, pc, instr
  );

  // commit side
  modport stage_in (
    input valid, kind, addr, rd, operand, write_en, pc, instr
  );

endinterface

// File: design/csr_pkg.sv
// machine CSR map is fixed at eight registers; only U and M modes exist
package csr_pkg;

  localparam int unsigned csr_addr_w = 12;
  localparam int unsigned priv_w = 2;
  localparam int unsigned cause_w = 4;

  // implemented machine CSRs
  localparam logic [csr_addr_w-1:0] addr_mstatus = 12'h300;
  localparam logic [csr_addr_w-1:0] addr_mie = 12'h304;
  localparam logic [csr_addr_w-1:0] addr_mtvec = 12'h305;
  localparam logic [csr_addr_w-1:0] addr_mscratch = 12'h340;
  localparam logic [csr_addr_w-1:0] addr_mepc = 12'h341;
  localparam logic [csr_addr_w-1:0] addr_mcause = 12'h342;
  localparam logic [csr_addr_w-1:0] addr_mtval = 12'h343;
  localparam logic [csr_addr_w-1:0] addr_mip = 12'h344;

  // privilege modes
  localparam logic [priv_w-1:0] priv_u = 2'b00;
  localparam logic [priv_w-1:0] priv_m = 2'b11;

  // synchronous exception codes
  localparam logic [cause_w-1:0] cause_illegal = 4'd2;
  localparam logic [cause_w-1:0] cause_ecall_u = 4'd8;
  localparam logic [cause_w-1:0] cause_ecall_m = 4'd11;

  // reset values
  localparam logic [31:0] mstatus_reset = 32'h0000_0008;
  localparam logic [31:0] mscratch_reset = 32'h0802_0000;

  // mstatus bit layout, msb first
  typedef struct packed {
    logic [18:0] rsvd_31_13;
    logic [1:0] mpp;
    logic [2:0] rsvd_10_8;
    logic mpie;
    logic [2:0] rsvd_6_4;
    logic mie;
    logic [2:0] rsvd_2_0;
  } mstatus_fields_t;

  // csr instructions see the whole word, trap logic sees the fields
  typedef union packed {
    logic [31:0] raw;
    mstatus_fields_t fields;
  } mstatus_t;

endpackage

// File: design/rv_isa_pkg.sv
// RV32 SYSTEM encodings only; other major opcodes are treated as illegal by the decoder
package rv_isa_pkg;

  // data path width
  localparam int unsigned xlen = 32;
  localparam int unsigned reg_idx_w = 5;

  // instruction field positions
  localparam int unsigned opcode_lsb = 0;
  localparam int unsigned opcode_w = 7;
  localparam int unsigned rd_lsb = 7;
  localparam int unsigned funct3_lsb = 12;
  localparam int unsigned funct3_w = 3;
  localparam int unsigned rs1_lsb = 15;
  localparam int unsigned imm_lsb = 20;
  localparam int unsigned imm_w = 12;

  // major opcode
  localparam logic [opcode_w-1:0] opcode_system = 7'b111_0011;

  // SYSTEM sub-operations
  localparam logic [funct3_w-1:0] funct3_priv = 3'b000;
  localparam logic [funct3_w-1:0] funct3_csrrw = 3'b001;
  localparam logic [funct3_w-1:0] funct3_csrrs = 3'b010;
  localparam logic [funct3_w-1:0] funct3_csrrc = 3'b011;
  localparam logic [funct3_w-1:0] funct3_csrrwi = 3'b101;
  localparam logic [funct3_w-1:0] funct3_csrrsi = 3'b110;
  localparam logic [funct3_w-1:0] funct3_csrrci = 3'b111;

  // immediates under funct3_priv
  localparam logic [imm_w-1:0] imm_ecall = 12'h000;
  localparam logic [imm_w-1:0] imm_mret = 12'h302;

  // operation classes seen by the CSR file
  typedef enum logic [2:0] {
    kind_csrw,
    kind_csrs,
    kind_csrc,
    kind_ecall,
    kind_mret,
    kind_illegal
  } sys_kind_t;

endpackage

// File: design/sys_unit_top.sv
// two-edge fixed latency from in_valid to wb or redirect; no back-pressure, one op per cycle
module sys_unit_top (
  input logic clk,
  input logic reset_x,

  // instruction issue
  input logic in_valid,
  input logic [rv_isa_pkg::xlen-1:0] in_instr,
  input logic [rv_isa_pkg::xlen-1:0] in_pc,
  input logic [rv_isa_pkg::xlen-1:0] in_rs1_data,

  // register writeback
  output logic wb_valid,
  output logic [rv_isa_pkg::reg_idx_w-1:0] wb_rd,
  output logic [rv_isa_pkg::xlen-1:0] wb_data,

  // fetch redirect
  output logic redirect_valid,
  output logic [rv_isa_pkg::xlen-1:0] redirect_pc,

  output logic [csr_pkg::priv_w-1:0] priv_mode
);

  // decode to commit
  csr_op_if u_op ();

  csr_decode u_decode (
    .clk(clk),
    .reset_x(reset_x),
    .in_valid(in_valid),
    .in_instr(in_instr),
    .in_pc(in_pc),
    .in_rs1_data(in_rs1_data),
    .op(u_op.stage_out)
  );

  csr_file u_csr (
    .clk(clk),
    .reset_x(reset_x),
    .op(u_op.stage_in),
    .wb_valid(wb_valid),
    .wb_rd(wb_rd),
    .wb_data(wb_data),
    .redirect_valid(redirect_valid),
    .redirect_pc(redirect_pc),
    .priv_mode(priv_mode)
  );

endmodule

// File: project.f
+incdir+tb
design/rv_isa_pkg.sv
design/csr_pkg.sv
design/csr_op_if.sv
design/csr_decode.sv
design/csr_file.sv
design/sys_unit_top.sv
tb/sys_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --timescale 1ns/100ps --top-module sys_unit_tb \
  -f project.f -o sys_unit_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sys_unit_sim > sim.log 2>&1 || echo "simulator returned a failing status" >> sim.log
cat sim.log
grep -q "ERRORS FOUND" sim.log && exit 1
grep -q "NO ERRORS" sim.log || exit 1
exit 0

// File: tb/sys_unit_tests.svh
// included inside sys_unit_tb; every instruction is checked two edges after it is issued

localparam logic [31:0] ecall_instr = {rv_isa_pkg::imm_ecall, 5'd0, rv_isa_pkg::funct3_priv,
    5'd0, rv_isa_pkg::opcode_system};
localparam logic [31:0] mret_instr = {rv_isa_pkg::imm_mret, 5'd0, rv_isa_pkg::funct3_priv,
    5'd0, rv_isa_pkg::opcode_system};

function automatic logic [31:0] csr_instr(input logic [2:0] f3, input logic [11:0] addr,
    input logic [4:0] src, input logic [4:0] rd);
  return {addr, src, f3, rd, rv_isa_pkg::opcode_system};
endfunction

function automatic logic [31:0] rand_word();
  return $random(seed);
endfunction

// called on a falling edge, returns one falling edge later
task automatic issue(input logic [31:0] instr, input logic [31:0] rs1);
  logic [31:0] pc;
  pc = rand_word();
  pc[1:0] = 2'b00;
  in_valid = 1'b1;
  in_instr = instr;
  in_pc = pc;
  in_rs1_data = rs1;
  q_instr.push_back(instr);
  q_pc.push_back(pc);
  q_rs1.push_back(rs1);
  @(negedge clk);
  in_valid = 1'b0;
endtask

task automatic run_one(input logic [31:0] instr, input logic [31:0] rs1);
  issue(instr, rs1);
  @(negedge clk);
  check_next();
endtask

task automatic csr_readback(input logic [11:0] addr);
  run_one(csr_instr(rv_isa_pkg::funct3_csrrs, addr, 5'd0, 5'd11), rand_word());
endtask

task automatic trap_csrs_readback();
  csr_readback(csr_pkg::addr_mcause);
  csr_readback(csr_pkg::addr_mtval);
endtask

task automatic reset_values_read();
  compare("wb_valid", {31'd0, wb_valid}, 32'd0);
  compare("redirect_valid", {31'd0, redirect_valid}, 32'd0);
  compare("priv_mode", {30'd0, priv_mode}, {30'd0, csr_pkg::priv_m});
  for (int i = 0; i < 8; i++) begin
    run_one(csr_instr(rv_isa_pkg::funct3_csrrs, csr_addrs[i], 5'd0, 5'd1), rand_word());
  end
endtask

// mstatus is left out so mpp keeps a legal mode
task automatic read_modify_write();
  logic [2:0] forms [7];
  logic [31:0] r;
  logic [11:0] addr;
  forms = '{rv_isa_pkg::funct3_csrrs, rv_isa_pkg::funct3_csrrc, rv_isa_pkg::funct3_csrrwi,
      rv_isa_pkg::funct3_csrrsi, rv_isa_pkg::funct3_csrrci, rv_isa_pkg::funct3_csrrw,
      rv_isa_pkg::funct3_csrrc};
  for (int k = 0; k < 7; k++) begin
    addr = csr_addrs[k + 1];
    r = rand_word();
    run_one(csr_instr(rv_isa_pkg::funct3_csrrw, addr, 5'd7, 5'd2), rand_word());
    run_one(csr_instr(forms[k], addr, r[4:0], 5'd3), rand_word());
    // rs1 = x0 reads without writing
    csr_readback(addr);
  end
  // two in flight on mscratch, each sees the write before it
  issue(csr_instr(rv_isa_pkg::funct3_csrrw, csr_pkg::addr_mscratch, 5'd8, 5'd5), rand_word());
  issue(csr_instr(rv_isa_pkg::funct3_csrrs, csr_pkg::addr_mscratch, 5'd9, 5'd6), rand_word());
  check_next();
  issue(csr_instr(rv_isa_pkg::funct3_csrrci, csr_pkg::addr_mscratch, 5'd21, 5'd7), rand_word());
  check_next();
  issue(csr_instr(rv_isa_pkg::funct3_csrrs, csr_pkg::addr_mscratch, 5'd0, 5'd8), rand_word());
  check_next();
  @(negedge clk);
  check_next();
endtask

task automatic ecall_trap();
  run_one(csr_instr(rv_isa_pkg::funct3_csrrw, csr_pkg::addr_mtvec, 5'd10, 5'd1), rand_word());
  run_one(ecall_instr, rand_word());
  csr_readback(csr_pkg::addr_mepc);
  csr_readback(csr_pkg::addr_mstatus);
  trap_csrs_readback();
endtask

task automatic mret_to_user();
  // clear mpp, then rd = x0 writes give no output at all
  run_one(csr_instr(rv_isa_pkg::funct3_csrrc, csr_pkg::addr_mstatus, 5'd12, 5'd0),
      32'h0000_1800);
  run_one(csr_instr(rv_isa_pkg::funct3_csrrw, csr_pkg::addr_mepc, 5'd13, 5'd0), rand_word());
  run_one(mret_instr, rand_word());
  // any CSR access from U traps
  run_one(csr_instr(rv_isa_pkg::funct3_csrrs, csr_pkg::addr_mscratch, 5'd0, 5'd14),
      rand_word());
  trap_csrs_readback();
  run_one(mret_instr, rand_word());
  run_one(ecall_instr, rand_word());
  csr_readback(csr_pkg::addr_mcause);
  run_one(mret_instr, rand_word());
  // mret from U is illegal
  run_one(mret_instr, rand_word());
  trap_csrs_readback();
endtask

task automatic illegal_encodings();
  run_one(csr_instr(rv_isa_pkg::funct3_csrrw, 12'h7c0, 5'd15, 5'd16), rand_word());
  trap_csrs_readback();
  run_one(csr_instr(3'b100, csr_pkg::addr_mscratch, 5'd1, 5'd17), rand_word());
  trap_csrs_readback();
  // add x3, x1, x2
  run_one(32'h0020_81b3, rand_word());
  trap_csrs_readback();
endtask

// File: tb/sys_unit_tb.sv
// stops at the first mismatch; mstatus only gets directed writes, so mpp always holds U or M
module sys_unit_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned cycle_limit = 400;

  // model slots, in the order of csr_addrs
  localparam int slot_mstatus = 0;
  localparam int slot_mtvec = 2;
  localparam int slot_mscratch = 3;
  localparam int slot_mepc = 4;
  localparam int slot_mcause = 5;
  localparam int slot_mtval = 6;
  localparam logic [11:0] csr_addrs [8] = '{
    csr_pkg::addr_mstatus, csr_pkg::addr_mie, csr_pkg::addr_mtvec, csr_pkg::addr_mscratch,
    csr_pkg::addr_mepc, csr_pkg::addr_mcause, csr_pkg::addr_mtval, csr_pkg::addr_mip
  };

  logic clk;
  logic reset_x;
  logic in_valid;
  logic [31:0] in_instr;
  logic [31:0] in_pc;
  logic [31:0] in_rs1_data;
  logic wb_valid;
  logic [4:0] wb_rd;
  logic [31:0] wb_data;
  logic redirect_valid;
  logic [31:0] redirect_pc;
  logic [1:0] priv_mode;

  // reference CSRs and mode
  logic [31:0] model_csr [8];
  logic [1:0] model_priv;

  // issued but not yet checked
  logic [31:0] q_instr [$];
  logic [31:0] q_pc [$];
  logic [31:0] q_rs1 [$];

  int seed = 44660;
  int unsigned cycle_count = 0;

  sys_unit_top u_sys_unit_top (
    .clk(clk),
    .reset_x(reset_x),
    .in_valid(in_valid),
    .in_instr(in_instr),
    .in_pc(in_pc),
    .in_rs1_data(in_rs1_data),
    .wb_valid(wb_valid),
    .wb_rd(wb_rd),
    .wb_data(wb_data),
    .redirect_valid(redirect_valid),
    .redirect_pc(redirect_pc),
    .priv_mode(priv_mode)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      stop_run("timeout, the tests did not finish within the cycle limit");
    end
  end

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("ERRORS FOUND");
    $fatal(1, "run stopped");
  endtask

  task automatic compare(input string name, input logic [31:0] got,
      input logic [31:0] expected);
    assert (got === expected) else begin
      stop_run($sformatf("[FAIL] %s got 0x%08h expected 0x%08h", name, got, expected));
    end
  endtask

  // -1 for an address outside the machine CSR map
  function automatic int slot_of(input logic [11:0] addr);
    int slot;
    slot = -1;
    for (int i = 0; i < 8; i++) begin
      if (csr_addrs[i] == addr) begin
        slot = i;
      end
    end
    return slot;
  endfunction

  // applies one instruction to the model and returns the response it predicts
  task automatic model_exec(
    input logic [31:0] instr,
    input logic [31:0] pc,
    input logic [31:0] rs1,
    output logic exp_wb,
    output logic [4:0] exp_rd,
    output logic [31:0] exp_data,
    output logic exp_redirect,
    output logic [31:0] exp_pc
  );
    logic [2:0] f3;
    logic [4:0] rs1_idx;
    logic [11:0] imm;
    logic [31:0] opnd;
    logic [31:0] old_val;
    logic [2:0] sel;
    int idx;
    logic trap;
    logic [3:0] cause;
    f3 = instr[14:12];
    rs1_idx = instr[19:15];
    imm = instr[31:20];
    idx = slot_of(imm);
    sel = idx[2:0];
    // immediate forms carry uimm in the rs1 field
    opnd = f3[2] ? {27'd0, rs1_idx} : rs1;
    exp_wb = 1'b0;
    exp_rd = instr[11:7];
    exp_data = '0;
    exp_redirect = 1'b0;
    exp_pc = '0;
    trap = 1'b1;
    cause = csr_pkg::cause_illegal;
    if (instr[6:0] != rv_isa_pkg::opcode_system || f3 == 3'b100) begin
      cause = csr_pkg::cause_illegal;
    end else if (f3 == rv_isa_pkg::funct3_priv) begin
      if (imm == rv_isa_pkg::imm_ecall) begin
        cause = (model_priv == csr_pkg::priv_m) ? csr_pkg::cause_ecall_m : csr_pkg::cause_ecall_u;
      end else if (imm == rv_isa_pkg::imm_mret && model_priv == csr_pkg::priv_m) begin
        trap = 1'b0;
        exp_redirect = 1'b1;
        exp_pc = model_csr[slot_mepc];
        model_priv = model_csr[slot_mstatus][12:11];
        model_csr[slot_mstatus][3] = model_csr[slot_mstatus][7];
        model_csr[slot_mstatus][7] = 1'b1;
        model_csr[slot_mstatus][12:11] = csr_pkg::priv_u;
      end
    end else if (idx >= 0 && model_priv == csr_pkg::priv_m) begin
      trap = 1'b0;
      old_val = model_csr[sel];
      exp_wb = (exp_rd != 5'd0);
      exp_data = old_val;
      case (f3[1:0])
        2'b01: begin
          model_csr[sel] = opnd;
        end
        2'b10: begin
          if (rs1_idx != 5'd0) begin
            model_csr[sel] = old_val | opnd;
          end
        end
        default: begin
          if (rs1_idx != 5'd0) begin
            model_csr[sel] = old_val & ~opnd;
          end
        end
      endcase
    end
    if (trap) begin
      exp_redirect = 1'b1;
      exp_pc = {model_csr[slot_mtvec][31:2], 2'b00};
      model_csr[slot_mepc] = pc;
      model_csr[slot_mcause] = {28'd0, cause};
      model_csr[slot_mstatus][7] = model_csr[slot_mstatus][3];
      model_csr[slot_mstatus][3] = 1'b0;
      model_csr[slot_mstatus][12:11] = model_priv;
      model_priv = csr_pkg::priv_m;
      if (cause == csr_pkg::cause_illegal) begin
        model_csr[slot_mtval] = instr;
      end
    end
  endtask

  // compares the outputs now on the pins with the oldest issued instruction
  task automatic check_next();
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] rs1;
    logic exp_wb;
    logic [4:0] exp_rd;
    logic [31:0] exp_data;
    logic exp_redirect;
    logic [31:0] exp_pc;
    instr = q_instr.pop_front();
    pc = q_pc.pop_front();
    rs1 = q_rs1.pop_front();
    model_exec(instr, pc, rs1, exp_wb, exp_rd, exp_data, exp_redirect, exp_pc);
    compare("wb_valid", {31'd0, wb_valid}, {31'd0, exp_wb});
    compare("redirect_valid", {31'd0, redirect_valid}, {31'd0, exp_redirect});
    if (exp_wb) begin
      compare("wb_rd", {27'd0, wb_rd}, {27'd0, exp_rd});
      compare("wb_data", wb_data, exp_data);
    end
    if (exp_redirect) begin
      compare("redirect_pc", redirect_pc, exp_pc);
    end
    compare("priv_mode", {30'd0, priv_mode}, {30'd0, model_priv});
  endtask

  `include "sys_unit_tests.svh"

  initial begin
    reset_x = 1'b0;
    in_valid = 1'b0;
    in_instr = '0;
    in_pc = '0;
    in_rs1_data = '0;
    for (int i = 0; i < 8; i++) begin
      model_csr[i] = '0;
    end
    model_csr[slot_mstatus] = 32'h0000_0008;
    model_csr[slot_mscratch] = 32'h0802_0000;
    model_priv = csr_pkg::priv_m;
    repeat (3) @(negedge clk);
    reset_x = 1'b1;
    reset_values_read();
    read_modify_write();
    ecall_trap();
    mret_to_user();
    illegal_encodings();
    $display("NO ERRORS");
    $finish;
  end

endmodule
